//--- replica_pkg.sv
`default_nettype none

package replica_pkg;

    localparam int BLOCK_LEN  = 200;   // cycles per optimisation block.
    localparam int SERIES_LEN = 15;    // taylor terms per exp window.
    localparam int RECIP_ONE  = 32768; // 1.0 in the reciprocal format.

    typedef logic [23:0] run_count_t;
    typedef logic [16:0] recip_t;

    typedef enum logic [1:0] {
        OR1,
        TWO,
        THR
    } opt_command_t;

    typedef enum logic [2:0] {
        KN,
        KM,
        KP,
        LN,
        LP,
        LM
    } dist_operand_t;

    typedef enum logic [1:0] {
        ZERO,
        MNS,
        PLS,
        DNOP
    } dist_op_t;

    typedef struct packed {
        dist_operand_t operand;
        dist_op_t      op;
    } distance_command_t;

    localparam distance_command_t DIST_NOP = '{KN, DNOP};

    typedef struct packed {
        logic opt_tick;  // 20, 40, ... 180.
        logic or_end;    // or-opt phase over.
        logic two_begin; // two-opt phase next.
        logic finish;    // last position of block.
        logic exp_init;
        logic exp_fin;
    } cycle_event_t;

endpackage

`default_nettype wire

//--- node_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module node_sequencer (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       run_write,
    input  replica_pkg::run_count_t    run_times,
    input  replica_pkg::cycle_event_t  cycle_events,
    output logic                       running,
    output logic                       start,
    output logic                       opt_run,
    output replica_pkg::opt_command_t  opt_com
);

    typedef enum logic {
        IDLE,
        RUN
    } seq_state_t;

    seq_state_t              state;
    replica_pkg::run_count_t run_times_q;
    replica_pkg::run_count_t pass_cnt;
    logic                    fin_pulse;
    logic                    last_pass;

    assign last_pass = (replica_pkg::run_count_t'(pass_cnt + 24'd2) == run_times_q);
    assign running   = (state == RUN);
    assign opt_run   = start | cycle_events.opt_tick | fin_pulse;

    always_ff @(posedge clk) begin
        if (run_write) begin
            run_times_q <= run_times;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            start     <= 1'b0;
            fin_pulse <= 1'b0;
            pass_cnt  <= '0;
            opt_com   <= replica_pkg::THR;
        end else begin
            start     <= 1'b0;
            fin_pulse <= 1'b0;
            if (run_write) begin // a new strobe restarts the run.
                state    <= RUN;
                start    <= 1'b1;
                pass_cnt <= '0;
                opt_com  <= replica_pkg::OR1;
            end else if (cycle_events.finish) begin
                if (last_pass) begin
                    state     <= IDLE;
                    fin_pulse <= 1'b1;
                    opt_com   <= replica_pkg::THR;
                end else begin
                    start    <= 1'b1;
                    pass_cnt <= replica_pkg::run_count_t'(pass_cnt + 24'd2);
                    opt_com  <= replica_pkg::OR1;
                end
            end else if (cycle_events.or_end) begin
                opt_com <= replica_pkg::THR;
            end else if (cycle_events.two_begin) begin
                opt_com <= replica_pkg::TWO;
            end
        end
    end

    a_run_times_even: assert property (@(posedge clk) disable iff (reset)
        run_write |-> (run_times != '0) && !run_times[0]);

    a_no_finish_idle: assert property (@(posedge clk) disable iff (reset)
        (state == IDLE) |-> !cycle_events.finish);

    // every block ends exactly one period after its start.
    a_block_period: assert property (@(posedge clk) disable iff (reset)
        cycle_events.finish |-> $past(start, replica_pkg::BLOCK_LEN - 1));

endmodule

`default_nettype wire

//--- cycle_timer.sv
`timescale 1ns/100ps
`default_nettype none

module cycle_timer (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start,
    output replica_pkg::cycle_event_t cycle_events
);

    logic [7:0] pos;   // 0 means idle or position 0.
    logic [7:0] phase; // position within the 20-cycle slot.
    logic       last;

    assign phase = pos % 8'd20;
    assign last  = (pos == 8'(replica_pkg::BLOCK_LEN - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            pos <= '0;
        end else if (start) begin
            pos <= 8'd1;
        end else if (last) begin
            pos <= '0;
        end else if (pos != '0) begin
            pos <= pos + 8'd1;
        end
    end

    always_comb begin
        cycle_events.opt_tick  = (phase == 8'd0) && (pos != '0);
        cycle_events.or_end    = (pos == 8'd19) || (pos == 8'd119);
        cycle_events.two_begin = (pos == 8'd99);
        cycle_events.finish    = last;
        cycle_events.exp_init  = (pos == 8'd40) || (pos == 8'd60) ||
                                 (pos == 8'd140) || (pos == 8'd160);
        cycle_events.exp_fin   = (phase == 8'd18);
    end

    a_pos_range: assert property (@(posedge clk) disable iff (reset)
        pos < 8'(replica_pkg::BLOCK_LEN));

endmodule

`default_nettype wire

//--- distance_stepper.sv
`timescale 1ns/100ps
`default_nettype none

module distance_stepper (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           opt_run,
    output replica_pkg::distance_command_t or_distance_com,
    output replica_pkg::distance_command_t tw_distance_com
);

    logic [2:0]                     stage;
    logic [2:0]                     stage_next;
    replica_pkg::distance_command_t or_next;
    replica_pkg::distance_command_t tw_next;

    // saturates at all ones so an idle node stays on nop.
    assign stage_next = opt_run ? 3'd0 : ((stage == 3'd7) ? stage : stage + 3'd1);

    always_comb begin
        case (stage_next)
            3'd0:    or_next = '{replica_pkg::KN, replica_pkg::ZERO};
            3'd1:    or_next = '{replica_pkg::KM, replica_pkg::MNS};
            3'd2:    or_next = '{replica_pkg::KP, replica_pkg::PLS};
            3'd3:    or_next = '{replica_pkg::KN, replica_pkg::MNS};
            3'd4:    or_next = '{replica_pkg::LN, replica_pkg::PLS};
            3'd5:    or_next = '{replica_pkg::LP, replica_pkg::MNS};
            3'd6:    or_next = '{replica_pkg::KN, replica_pkg::PLS};
            default: or_next = replica_pkg::DIST_NOP;
        endcase
        case (stage_next)
            3'd0:    tw_next = '{replica_pkg::KN, replica_pkg::ZERO};
            3'd1:    tw_next = '{replica_pkg::KM, replica_pkg::MNS};
            3'd2:    tw_next = '{replica_pkg::LM, replica_pkg::PLS};
            3'd3:    tw_next = '{replica_pkg::LN, replica_pkg::MNS};
            3'd4:    tw_next = '{replica_pkg::KN, replica_pkg::PLS};
            default: tw_next = replica_pkg::DIST_NOP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage           <= 3'd7;
            or_distance_com <= replica_pkg::DIST_NOP;
            tw_distance_com <= replica_pkg::DIST_NOP;
        end else begin
            stage           <= stage_next;
            or_distance_com <= or_next;
            tw_distance_com <= tw_next;
        end
    end

endmodule

`default_nettype wire

//--- recip_series.sv
`timescale 1ns/100ps
`default_nettype none

module recip_series (
    input  logic                clk,
    input  logic                reset,
    input  logic                exp_init,
    output logic                exp_run,
    output replica_pkg::recip_t exp_recip
);

    logic [3:0] count; // term index, runs 15 down to 1.

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (exp_init) begin
            count <= 4'(replica_pkg::SERIES_LEN);
        end else if (count != '0) begin
            count <= count - 4'd1;
        end
    end

    assign exp_run = (count != '0);

    always_comb begin
        case (count)
            4'd1:    exp_recip = replica_pkg::recip_t'(replica_pkg::RECIP_ONE / 1);
            4'd2:    exp_recip = replica_pkg::recip_t'(replica_pkg::RECIP_ONE / 2);
            4'd3:    exp_recip = replica_pkg::recip_t'(replica_pkg::RECIP_ONE / 3);
            4'd4:    exp_recip = replica_pkg::recip_t'(replica_pkg::RECIP_ONE / 4);
            4'd5:    exp_recip = replica_pkg::recip_t'(replica_pkg::RECIP_ONE / 5);
            4'd6:    exp_recip = replica_pkg::recip_t'(replica_pkg::RECIP_ONE / 6);
            4'd7:    exp_recip = replica_pkg::recip_t'(replica_pkg::RECIP_ONE / 7);
            4'd8:    exp_recip = replica_pkg::recip_t'(replica_pkg::RECIP_ONE / 8);
            4'd9:    exp_recip = replica_pkg::recip_t'(replica_pkg::RECIP_ONE / 9);
            4'd10:   exp_recip = replica_pkg::recip_t'(replica_pkg::RECIP_ONE / 10);
            4'd11:   exp_recip = replica_pkg::recip_t'(replica_pkg::RECIP_ONE / 11);
            4'd12:   exp_recip = replica_pkg::recip_t'(replica_pkg::RECIP_ONE / 12);
            4'd13:   exp_recip = replica_pkg::recip_t'(replica_pkg::RECIP_ONE / 13);
            4'd14:   exp_recip = replica_pkg::recip_t'(replica_pkg::RECIP_ONE / 14);
            4'd15:   exp_recip = replica_pkg::recip_t'(replica_pkg::RECIP_ONE / 15);
            default: exp_recip = '0; // no window open.
        endcase
    end

    // windows from the timer never overlap.
    a_init_idle: assert property (@(posedge clk) disable iff (reset)
        exp_init |-> !exp_run);

endmodule

`default_nettype wire

//--- replica_node.sv
`timescale 1ns/100ps
`default_nettype none

module replica_node (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           run_write,
    input  replica_pkg::run_count_t        run_times,
    output logic                           running,
    output logic                           opt_run,
    output replica_pkg::opt_command_t      opt_com,
    output replica_pkg::distance_command_t or_distance_com,
    output replica_pkg::distance_command_t tw_distance_com,
    output logic                           exp_init,
    output logic                           exp_run,
    output logic                           exp_fin,
    output replica_pkg::recip_t            exp_recip
);

    logic                      start;
    replica_pkg::cycle_event_t cycle_events;

    node_sequencer i_node_sequencer (
        .clk          (clk),
        .reset        (reset),
        .run_write    (run_write),
        .run_times    (run_times),
        .cycle_events (cycle_events),
        .running      (running),
        .start        (start),
        .opt_run      (opt_run),
        .opt_com      (opt_com)
    );

    cycle_timer i_cycle_timer (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .cycle_events (cycle_events)
    );

    distance_stepper i_distance_stepper (
        .clk             (clk),
        .reset           (reset),
        .opt_run         (opt_run),
        .or_distance_com (or_distance_com),
        .tw_distance_com (tw_distance_com)
    );

    recip_series i_recip_series (
        .clk       (clk),
        .reset     (reset),
        .exp_init  (cycle_events.exp_init),
        .exp_run   (exp_run),
        .exp_recip (exp_recip)
    );

    assign exp_init = cycle_events.exp_init;
    assign exp_fin  = cycle_events.exp_fin;

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period.
    end

    initial begin
        reset <= 1'b1;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

//--- tb_replica_node.sv
`timescale 1ns/100ps
`default_nettype none

module tb_replica_node;

    logic                           clk;
    logic                           reset;
    logic                           run_write;
    replica_pkg::run_count_t        run_times;
    logic                           running;
    logic                           opt_run;
    replica_pkg::opt_command_t      opt_com;
    replica_pkg::distance_command_t or_distance_com;
    replica_pkg::distance_command_t tw_distance_com;
    logic                           exp_init;
    logic                           exp_run;
    logic                           exp_fin;
    replica_pkg::recip_t            exp_recip;

    logic                    rw_q;          // strobe driven in the last cycle.
    replica_pkg::run_count_t rt_q;
    logic                    m_active;
    logic                    m_fin;
    int                      m_pos;
    int                      m_blocks_left;
    int                      m_k;           // cycles since last opt_run.
    int                      m_exp_j;       // step inside the exp window.
    logic                    prev_opt_run;
    logic                    prev_exp_init;

    tb_clock_gen i_tb_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    replica_node i_replica_node (
        .clk             (clk),
        .reset           (reset),
        .run_write       (run_write),
        .run_times       (run_times),
        .running         (running),
        .opt_run         (opt_run),
        .opt_com         (opt_com),
        .or_distance_com (or_distance_com),
        .tw_distance_com (tw_distance_com),
        .exp_init        (exp_init),
        .exp_run         (exp_run),
        .exp_fin         (exp_fin),
        .exp_recip       (exp_recip)
    );

    function automatic replica_pkg::distance_command_t or_script(input int idx);
        replica_pkg::distance_command_t cmd;
        case (idx)
            0:       cmd = '{replica_pkg::KN, replica_pkg::ZERO};
            1:       cmd = '{replica_pkg::KM, replica_pkg::MNS};
            2:       cmd = '{replica_pkg::KP, replica_pkg::PLS};
            3:       cmd = '{replica_pkg::KN, replica_pkg::MNS};
            4:       cmd = '{replica_pkg::LN, replica_pkg::PLS};
            5:       cmd = '{replica_pkg::LP, replica_pkg::MNS};
            6:       cmd = '{replica_pkg::KN, replica_pkg::PLS};
            default: cmd = '{replica_pkg::KN, replica_pkg::DNOP};
        endcase
        return cmd;
    endfunction

    function automatic replica_pkg::distance_command_t two_script(input int idx);
        replica_pkg::distance_command_t cmd;
        case (idx)
            0:       cmd = '{replica_pkg::KN, replica_pkg::ZERO};
            1:       cmd = '{replica_pkg::KM, replica_pkg::MNS};
            2:       cmd = '{replica_pkg::LM, replica_pkg::PLS};
            3:       cmd = '{replica_pkg::LN, replica_pkg::MNS};
            4:       cmd = '{replica_pkg::KN, replica_pkg::PLS};
            default: cmd = '{replica_pkg::KN, replica_pkg::DNOP};
        endcase
        return cmd;
    endfunction

    function automatic replica_pkg::opt_command_t phase_command(input logic active, input int pos);
        if (!active || pos >= 120) return replica_pkg::THR;
        if (pos < 20) return replica_pkg::OR1;
        if (pos < 100) return replica_pkg::THR;
        return replica_pkg::TWO;
    endfunction

    function automatic replica_pkg::recip_t taylor_recip(input int j);
        if (j == 0) return '0;
        return replica_pkg::recip_t'(32768 / (16 - j)); // n runs 15 down to 1.
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("FAILED at time %0t: %s is %0h, expected %0h", $time, what, got, expected);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1);
    endtask

    // one clock of the model, using the strobe of the cycle before.
    task automatic advance_model();
        if (prev_opt_run) begin
            m_k = 1;
        end else if (m_k < 64) begin
            m_k = m_k + 1;
        end
        if (prev_exp_init) begin
            m_exp_j = 1;
        end else if (m_exp_j != 0 && m_exp_j < replica_pkg::SERIES_LEN) begin
            m_exp_j = m_exp_j + 1;
        end else begin
            m_exp_j = 0;
        end
        m_fin = 1'b0;
        if (rw_q) begin
            m_active      = 1'b1;
            m_pos         = 0;
            m_blocks_left = int'(rt_q) / 2;
        end else if (m_active) begin
            if (m_pos == replica_pkg::BLOCK_LEN - 1) begin
                m_blocks_left = m_blocks_left - 1;
                m_pos         = 0;
                if (m_blocks_left == 0) begin
                    m_active = 1'b0;
                    m_fin    = 1'b1; // closing opt_run.
                end
            end else begin
                m_pos = m_pos + 1;
            end
        end
    endtask

    task automatic compare_outputs();
        logic e_opt_run;
        logic e_exp_init;
        logic e_exp_fin;
        e_opt_run  = m_fin || (m_active && (m_pos % 20 == 0));
        e_exp_init = m_active && (m_pos == 40 || m_pos == 60 || m_pos == 140 || m_pos == 160);
        e_exp_fin  = m_active && (m_pos % 20 == 18);
        check_value("running", 32'(running), 32'(m_active));
        check_value("opt_run", 32'(opt_run), 32'(e_opt_run));
        check_value("opt_com", 32'(opt_com), 32'(phase_command(m_active, m_pos)));
        check_value("or_distance_com", 32'(or_distance_com), 32'(or_script(m_k - 1)));
        check_value("tw_distance_com", 32'(tw_distance_com), 32'(two_script(m_k - 1)));
        check_value("exp_init", 32'(exp_init), 32'(e_exp_init));
        check_value("exp_fin", 32'(exp_fin), 32'(e_exp_fin));
        check_value("exp_run", 32'(exp_run), 32'(m_exp_j != 0));
        check_value("exp_recip", 32'(exp_recip), 32'(taylor_recip(m_exp_j)));
        prev_opt_run  = e_opt_run;
        prev_exp_init = e_exp_init;
    endtask

    // drive on the rising edge, check at the falling edge.
    task automatic run_cycle(input logic rw, input replica_pkg::run_count_t rt);
        @(posedge clk);
        advance_model();
        run_write <= rw;
        run_times <= rt;
        rw_q = rw;
        rt_q = rt;
        @(negedge clk);
        compare_outputs();
    endtask

    initial begin
        int                      wait_cycles;
        int                      run_cycles;
        int                      pulse_count;
        int                      gap;
        replica_pkg::run_count_t rt;
        run_write     <= 1'b0;
        run_times     <= '0;
        rw_q          = 1'b0;
        rt_q          = '0;
        m_active      = 1'b0;
        m_fin         = 1'b0;
        m_pos         = 0;
        m_blocks_left = 0;
        m_k           = 64;
        m_exp_j       = 0;
        prev_opt_run  = 1'b0;
        prev_exp_init = 1'b0;
        wait_cycles   = 0;
        do begin
            @(negedge clk);
            wait_cycles = wait_cycles + 1;
            if (wait_cycles > 20) abort_run("reset was never released");
        end while (reset !== 1'b0);
        void'($urandom(32'ha1f1));
        repeat (4) run_cycle(1'b0, '0);
        for (int r = 0; r < 8; r++) begin
            rt  = replica_pkg::run_count_t'(2 * (1 + ($urandom % 4)));
            gap = int'($urandom % 31);
            run_cycle(1'b1, rt);
            run_cycles  = 0;
            pulse_count = 0;
            wait_cycles = 0;
            do begin
                run_cycle(1'b0, '0);
                if (running) run_cycles = run_cycles + 1;
                if (opt_run) pulse_count = pulse_count + 1;
                wait_cycles = wait_cycles + 1;
                if (wait_cycles > 100 * int'(rt) + 20) abort_run("run did not end in time");
            end while (running);
            check_value("running length", 32'(run_cycles), 32'(100 * int'(rt)));
            check_value("opt_run count", 32'(pulse_count), 32'(5 * int'(rt) + 1));
            repeat (gap) run_cycle(1'b0, '0);
        end
        repeat (10) run_cycle(1'b0, '0);
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- replica_node.f
replica_pkg.sv
node_sequencer.sv
cycle_timer.sv
distance_stepper.sv
recip_series.sv
replica_node.sv
tb_clock_gen.sv
tb_replica_node.sv

//--- run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_replica_node -o tb_replica_node \
    -f replica_node.f

./obj_dir/tb_replica_node > sim.log 2>&1 || true
cat sim.log

if grep -q "^Test OK$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
